// File: sys_settings.svh
/*
 * Shared sizing macros for the system layer
 * Audio sample width and sample FIFO depth
 * Host word width and board LED count
 * Width of the volume attenuation shift field
 */

`ifndef SYS_SETTINGS_SVH
`define SYS_SETTINGS_SVH

// ==========================================================================
// Audio path
// ==========================================================================

// Bits per channel
`define SAMPLE_W 16

// Stereo entries held between mixer and volume stage
`define SAMPLE_FIFO_DEPTH 4

// ==========================================================================
// Host port and board
// ==========================================================================

`define HOST_W 16
`define LED_W 8

// Right shift 0 to 15
`define VOL_SHIFT_W 4

`endif

// File: host_pkg.sv
/*
 * Host side types
 * Command opcodes, configuration word layout,
 * LED overtake control, volume attenuation and core LED status
 */

`include "sys_settings.svh"

package host_pkg;

	// Opcodes carried in the first word of a command
	typedef enum logic [7:0] {
		CMD_CFG = 8'h01,
		CMD_LED = 8'h25,
		CMD_VOL = 8'h26
	} host_opcode_t;

	// Core configuration word, one host word wide
	typedef struct packed {
		logic [7:0] rsvd_hi;
		logic       dvi_mode;
		logic       audio_96k;
		logic       ypbpr_en;
		logic       rsvd_4;
		logic       csync;
		logic [2:0] rsvd_lo;
	} cfg_flags_t;

	// Overtake mask in the high half, pattern in the low half
	typedef struct packed {
		logic [`LED_W-1:0] overtake;
		logic [`LED_W-1:0] state;
	} led_ctl_t;

	typedef struct packed {
		logic                    mute;
		logic [`VOL_SHIFT_W-1:0] shift;
	} vol_att_t;

	// Bit 1 of each pair forces, bit 0 is the value
	typedef struct packed {
		logic [1:0] power_ctl;
		logic [1:0] disk_ctl;
		logic       user;
	} core_led_t;

endpackage

// File: audio_pkg.sv
/*
 * Audio types and helpers
 * Stereo sample, cross-mix depth and sample format
 * Right shift honouring sample signedness
 */

`include "sys_settings.svh"

package audio_pkg;

	typedef struct packed {
		logic [`SAMPLE_W-1:0] left;
		logic [`SAMPLE_W-1:0] right;
	} stereo_sample_t;

	// Share of the opposite channel mixed in
	typedef enum logic [1:0] {
		MIX_NONE    = 2'd0,
		MIX_EIGHTH  = 2'd1,
		MIX_QUARTER = 2'd2,
		MIX_HALF    = 2'd3
	} mix_depth_t;

	typedef struct packed {
		logic       is_signed;
		mix_depth_t depth;
	} audio_fmt_t;

	// Arithmetic shift for signed audio, logical for unsigned
	function automatic logic [`SAMPLE_W-1:0] sample_shr(
		input logic [`SAMPLE_W-1:0]    value,
		input logic [`VOL_SHIFT_W-1:0] amount,
		input logic                    is_signed
	);
		logic [`SAMPLE_W-1:0] res;
		if (is_signed) begin
			res = $signed(value) >>> amount;
		end else begin
			res = value >> amount;
		end
		return res;
	endfunction

endpackage

// File: host_cmd_decoder.sv
/*
 * Host command decoder
 * Two-stage capture of the host word port and strobe detection
 * Opcode/data sequencing and the loaded configuration, LED and volume registers
 */

`include "sys_settings.svh"

module host_cmd_decoder
	import host_pkg::*;
(
	input  logic               clk_sys,
	input  logic               resetd,
	input  logic               host_uio,
	input  logic               host_clk,
	input  logic [`HOST_W-1:0] host_din,
	output cfg_flags_t         cfg_flags,
	output led_ctl_t           led_ctl,
	output vol_att_t           vol_att
);

	typedef enum logic {
		ST_OPCODE,
		ST_DATA
	} dec_state_t;

	logic [1:0]         uio_sync;
	logic [1:0]         clk_sync;
	logic [`HOST_W-1:0] din_s1;
	logic [`HOST_W-1:0] din_s2;
	logic [`HOST_W-1:0] din_q;
	logic               clk_prev;
	logic               strobe;
	logic               uio_q;
	dec_state_t         state;
	host_opcode_t       opcode;

	// ======================================================================
	// Input capture and strobe
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			uio_sync <= '0;
			clk_sync <= '0;
			clk_prev <= 1'b0;
			strobe   <= 1'b0;
			uio_q    <= 1'b0;
		end else begin
			uio_sync <= {uio_sync[0], host_uio};
			clk_sync <= {clk_sync[0], host_clk};
			clk_prev <= clk_sync[1];
			// One pulse per rising edge of the captured host clock
			strobe   <= clk_sync[1] & ~clk_prev;
			uio_q    <= uio_sync[1];
		end
	end

	// Word stays aligned with the strobe pulse
	always_ff @(posedge clk_sys) begin
		din_s1 <= host_din;
		din_s2 <= din_s1;
		din_q  <= din_s2;
	end

	// ======================================================================
	// Command decode
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state     <= ST_OPCODE;
			cfg_flags <= '0;
			led_ctl   <= '0;
			vol_att   <= '0;
		end else if (!uio_q) begin
			// Command window closed
			state <= ST_OPCODE;
		end else if (strobe) begin
			if (state == ST_OPCODE) begin
				opcode <= host_opcode_t'(din_q[7:0]);
				state  <= ST_DATA;
			end else begin
				// Every data word reloads, so the last one sticks
				case (opcode)
					CMD_CFG: cfg_flags <= cfg_flags_t'(din_q);
					CMD_LED: led_ctl   <= led_ctl_t'(din_q);
					CMD_VOL: vol_att   <= vol_att_t'(din_q[$bits(vol_att_t)-1:0]);
					default: ;
				endcase
			end
		end
	end

endmodule

// File: audio_mixer.sv
/*
 * Stereo cross-mixer
 * Blends each channel with the opposite one in four depths,
 * signed or unsigned, behind a single output register
 */

`include "sys_settings.svh"

module audio_mixer
	import audio_pkg::*;
(
	input  logic           clk_sys,
	input  logic           resetd,
	input  stereo_sample_t in_sample,
	input  logic           in_valid,
	input  audio_fmt_t     audio_fmt,
	output logic           in_ready,
	output stereo_sample_t mix_sample,
	output logic           mix_valid,
	input  logic           mix_ready
);

	stereo_sample_t mix_next;
	logic           accept;

	// Own channel with a share of the other, wraps at the sample width
	function automatic logic [`SAMPLE_W-1:0] blend(
		input logic [`SAMPLE_W-1:0] own,
		input logic [`SAMPLE_W-1:0] other,
		input audio_fmt_t           fmt
	);
		logic [`SAMPLE_W-1:0] res;
		case (fmt.depth)
			MIX_NONE: res = own;
			MIX_EIGHTH: res = own - sample_shr(own, `VOL_SHIFT_W'(3), fmt.is_signed)
				+ sample_shr(other, `VOL_SHIFT_W'(3), fmt.is_signed);
			MIX_QUARTER: res = own - sample_shr(own, `VOL_SHIFT_W'(2), fmt.is_signed)
				+ sample_shr(other, `VOL_SHIFT_W'(2), fmt.is_signed);
			MIX_HALF: res = sample_shr(own, `VOL_SHIFT_W'(1), fmt.is_signed)
				+ sample_shr(other, `VOL_SHIFT_W'(1), fmt.is_signed);
			default: res = own;
		endcase
		return res;
	endfunction

	always_comb begin
		mix_next.left  = blend(in_sample.left, in_sample.right, audio_fmt);
		mix_next.right = blend(in_sample.right, in_sample.left, audio_fmt);
	end

	// Take a sample when the register is empty or being drained
	assign in_ready = !mix_valid || mix_ready;
	assign accept   = in_valid && in_ready;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			mix_valid <= 1'b0;
		end else if (accept) begin
			mix_valid <= 1'b1;
		end else if (mix_ready) begin
			mix_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			mix_sample <= mix_next;
		end
	end

endmodule

// File: sample_fifo.sv
/*
 * Stereo sample FIFO
 * Circular buffer with read/write pointers and occupancy count,
 * valid/ready on both sides
 */

`include "sys_settings.svh"

module sample_fifo
	import audio_pkg::*;
(
	input  logic           clk_sys,
	input  logic           resetd,
	input  stereo_sample_t wr_sample,
	input  logic           wr_valid,
	output logic           wr_ready,
	output stereo_sample_t rd_sample,
	output logic           rd_valid,
	input  logic           rd_ready
);

	localparam int PTR_W = $clog2(`SAMPLE_FIFO_DEPTH);
	localparam int CNT_W = $clog2(`SAMPLE_FIFO_DEPTH + 1);

	stereo_sample_t mem [`SAMPLE_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_wr;
	logic             do_rd;

	assign wr_ready  = count != CNT_W'(`SAMPLE_FIFO_DEPTH);
	assign rd_valid  = count != '0;
	assign rd_sample = mem[rd_ptr];

	assign do_wr = wr_valid && wr_ready;
	assign do_rd = rd_valid && rd_ready;

	// Pointers wrap explicitly so any depth works
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == PTR_W'(`SAMPLE_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == PTR_W'(`SAMPLE_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_sample;
		end
	end

endmodule

// File: volume_stage.sv
/*
 * Volume stage
 * Mutes or right-shifts both channels by the host attenuation,
 * latched at the moment each sample is accepted
 */

`include "sys_settings.svh"

module volume_stage
	import host_pkg::*;
	import audio_pkg::*;
(
	input  logic           clk_sys,
	input  logic           resetd,
	input  stereo_sample_t in_sample,
	input  logic           in_valid,
	input  vol_att_t       vol_att,
	input  logic           is_signed,
	output logic           in_ready,
	output stereo_sample_t out_sample,
	output logic           out_valid,
	input  logic           out_ready
);

	stereo_sample_t att_sample;
	logic           accept;

	always_comb begin
		if (vol_att.mute) begin
			att_sample = '0;
		end else begin
			att_sample.left  = sample_shr(in_sample.left, vol_att.shift, is_signed);
			att_sample.right = sample_shr(in_sample.right, vol_att.shift, is_signed);
		end
	end

	assign in_ready = !out_valid || out_ready;
	assign accept   = in_valid && in_ready;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			out_valid <= 1'b0;
		end else if (accept) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// Held while the sink stalls
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			out_sample <= att_sample;
		end
	end

endmodule

// File: led_driver.sv
/*
 * Board LED driver
 * Registered core status pattern merged with the host overtake
 */

`include "sys_settings.svh"

module led_driver
	import host_pkg::*;
(
	input  logic              clk_sys,
	input  logic              resetd,
	input  led_ctl_t          led_ctl,
	input  core_led_t         core_led,
	output logic [`LED_W-1:0] board_led
);

	logic [`LED_W-1:0] status;

	// User on bit 0, disk on bit 2, power on bit 4
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			status <= '0;
		end else begin
			status    <= '0;
			status[0] <= core_led.user;
			status[2] <= core_led.disk_ctl[0];
			// Power lit unless the core forces it
			status[4] <= core_led.power_ctl[1] ? core_led.power_ctl[0] : 1'b1;
		end
	end

	assign board_led = (led_ctl.overtake & led_ctl.state) | (~led_ctl.overtake & status);

endmodule

// File: sys_top.sv
/*
 * System layer top level
 * Host command decoder, audio chain of mixer, FIFO and volume stage,
 * and the board LED driver
 */

`include "sys_settings.svh"

module sys_top
	import host_pkg::*;
	import audio_pkg::*;
(
	input  logic               clk_sys,
	input  logic               resetd,
	input  logic               host_uio,
	input  logic               host_clk,
	input  logic [`HOST_W-1:0] host_din,
	input  stereo_sample_t     core_sample,
	input  logic               core_valid,
	output logic               core_ready,
	input  audio_fmt_t         audio_fmt,
	input  core_led_t          core_led,
	output stereo_sample_t     out_sample,
	output logic               out_valid,
	input  logic               out_ready,
	output logic [`LED_W-1:0]  board_led,
	output cfg_flags_t         cfg_flags
);

	led_ctl_t       led_ctl;
	vol_att_t       vol_att;
	stereo_sample_t mix_sample;
	logic           mix_valid;
	logic           mix_ready;
	stereo_sample_t fifo_sample;
	logic           fifo_valid;
	logic           fifo_ready;

	// ======================================================================
	// Host side
	// ======================================================================

	host_cmd_decoder i_host_cmd_decoder (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.host_uio  (host_uio),
		.host_clk  (host_clk),
		.host_din  (host_din),
		.cfg_flags (cfg_flags),
		.led_ctl   (led_ctl),
		.vol_att   (vol_att)
	);

	led_driver i_led_driver (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.led_ctl   (led_ctl),
		.core_led  (core_led),
		.board_led (board_led)
	);

	// ======================================================================
	// Audio chain
	// ======================================================================

	audio_mixer i_audio_mixer (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.in_sample  (core_sample),
		.in_valid   (core_valid),
		.audio_fmt  (audio_fmt),
		.in_ready   (core_ready),
		.mix_sample (mix_sample),
		.mix_valid  (mix_valid),
		.mix_ready  (mix_ready)
	);

	sample_fifo i_sample_fifo (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.wr_sample (mix_sample),
		.wr_valid  (mix_valid),
		.wr_ready  (mix_ready),
		.rd_sample (fifo_sample),
		.rd_valid  (fifo_valid),
		.rd_ready  (fifo_ready)
	);

	volume_stage i_volume_stage (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.in_sample  (fifo_sample),
		.in_valid   (fifo_valid),
		.vol_att    (vol_att),
		.is_signed  (audio_fmt.is_signed),
		.in_ready   (fifo_ready),
		.out_sample (out_sample),
		.out_valid  (out_valid),
		.out_ready  (out_ready)
	);

endmodule

// File: tb_sys_top.sv
/*
 * Testbench for the system layer top level
 * Clock, reset, host command writes and audio stimulus
 * Queue reference model of the mix and attenuation, checked by assertions
 */

`include "sys_settings.svh"

module tb_sys_top
	import host_pkg::*;
	import audio_pkg::*;
;

	localparam int TIMEOUT_CYCLES = 20000;
	localparam int FMT_SAMPLES    = 200;
	localparam int BP_SAMPLES     = 600;
	localparam int VOL_SAMPLES    = 100;

	logic               clk_sys;
	logic               resetd;
	logic               host_uio;
	logic               host_clk;
	logic [`HOST_W-1:0] host_din;
	stereo_sample_t     core_sample;
	logic               core_valid;
	logic               core_ready;
	audio_fmt_t         audio_fmt;
	core_led_t          core_led;
	stereo_sample_t     out_sample;
	logic               out_valid;
	logic               out_ready;
	logic [`LED_W-1:0]  board_led;
	cfg_flags_t         cfg_flags;

	stereo_sample_t     exp_q[$];
	stereo_sample_t     want_s;
	stereo_sample_t     held_sample;
	logic               held_valid;
	vol_att_t           model_vol;
	led_ctl_t           model_led;
	logic               bp_en;
	int unsigned        seed_ret;
	int                 cycles;
	int                 in_count;
	int                 out_count;
	int                 data_errs;
	int                 proto_errs;

	sys_top i_sys_top (.*);

	// ======================================================================
	// Reference rules
	// ======================================================================

	// Sign extend first, then a plain shift
	function automatic logic [`SAMPLE_W-1:0] shift_down(
		input logic [`SAMPLE_W-1:0] v,
		input int                   n,
		input logic                 sgn
	);
		logic [2*`SAMPLE_W-1:0] wide;
		wide = {{`SAMPLE_W{sgn & v[`SAMPLE_W-1]}}, v};
		wide = wide >> n;
		return wide[`SAMPLE_W-1:0];
	endfunction

	function automatic logic [`SAMPLE_W-1:0] blend_channel(
		input logic [`SAMPLE_W-1:0] own,
		input logic [`SAMPLE_W-1:0] other,
		input audio_fmt_t           fmt
	);
		logic [`SAMPLE_W-1:0] res;
		case (fmt.depth)
			MIX_EIGHTH: res = own - shift_down(own, 3, fmt.is_signed)
				+ shift_down(other, 3, fmt.is_signed);
			MIX_QUARTER: res = own - shift_down(own, 2, fmt.is_signed)
				+ shift_down(other, 2, fmt.is_signed);
			MIX_HALF: res = shift_down(own, 1, fmt.is_signed)
				+ shift_down(other, 1, fmt.is_signed);
			default: res = own;
		endcase
		return res;
	endfunction

	function automatic stereo_sample_t expected_output(
		input stereo_sample_t s,
		input audio_fmt_t     fmt,
		input vol_att_t       vol
	);
		stereo_sample_t m;
		stereo_sample_t r;
		m.left  = blend_channel(s.left, s.right, fmt);
		m.right = blend_channel(s.right, s.left, fmt);
		r = '0;
		if (!vol.mute) begin
			r.left  = shift_down(m.left, vol.shift, fmt.is_signed);
			r.right = shift_down(m.right, vol.shift, fmt.is_signed);
		end
		return r;
	endfunction

	// User on 0, disk value on 2, power on 4 unless forced
	function automatic logic [`LED_W-1:0] expected_leds(
		input led_ctl_t  ctl,
		input core_led_t c
	);
		logic [`LED_W-1:0] pat;
		pat    = '0;
		pat[0] = c.user;
		pat[2] = c.disk_ctl[0];
		pat[4] = c.power_ctl[1] ? c.power_ctl[0] : 1'b1;
		return (ctl.overtake & ctl.state) | (~ctl.overtake & pat);
	endfunction

	task automatic check_value(
		input string       what,
		input logic [31:0] got,
		input logic [31:0] want
	);
		assert (got === want) else begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
			data_errs++;
		end
	endtask

	// ======================================================================
	// Clock, ready driver, monitor and timeout
	// ======================================================================

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		#1;
		out_ready = bp_en ? ($urandom % 3 == 0) : 1'b1;
	end

	// Everything settles by the falling edge
	always @(negedge clk_sys) begin
		if (!resetd) begin
			// Mixer, FIFO and volume stage all full before the input stalls
			if (!core_ready) begin
				assert (exp_q.size() == `SAMPLE_FIFO_DEPTH + 2) else begin
					$display("Input stalled at time %0t with %0d samples in flight",
						$time, exp_q.size());
					proto_errs++;
				end
			end
			if (core_valid && core_ready) begin
				exp_q.push_back(expected_output(core_sample, audio_fmt, model_vol));
				in_count++;
			end
			if (held_valid) begin
				assert (out_valid && out_sample === held_sample) else begin
					$display("Output changed at time %0t while the sink stalled", $time);
					proto_errs++;
				end
			end
			if (out_valid && out_ready) begin
				out_count++;
				if (exp_q.size() == 0) begin
					$display("Output appeared at time %0t with no sample expected", $time);
					proto_errs++;
				end else begin
					want_s = exp_q.pop_front();
					check_value("out_sample", out_sample, want_s);
				end
			end
			held_valid  = out_valid && !out_ready;
			held_sample = out_sample;
		end
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
		$display("Errors: data %0d, protocol %0d", data_errs, proto_errs);
		$display("Finished with errors");
		$finish;
	end

	// ======================================================================
	// Host and audio tasks
	// ======================================================================

	// Opcode strobe, then data strobe held high; returns 4 cycles after it
	task automatic host_command(input logic [7:0] op, input logic [`HOST_W-1:0] data);
		host_uio = 1'b1;
		repeat (4) @(posedge clk_sys);
		#1;
		host_din = {8'h00, op};
		host_clk = 1'b1;
		repeat (4) @(posedge clk_sys);
		#1;
		host_clk = 1'b0;
		repeat (4) @(posedge clk_sys);
		#1;
		host_din = data;
		host_clk = 1'b1;
		repeat (4) @(posedge clk_sys);
		#1;
	endtask

	task automatic host_close();
		host_clk = 1'b0;
		repeat (4) @(posedge clk_sys);
		#1;
		host_uio = 1'b0;
		repeat (4) @(posedge clk_sys);
		#1;
	endtask

	task automatic set_volume(input vol_att_t v);
		host_command(CMD_VOL, `HOST_W'(v));
		model_vol = v;
		host_close();
	endtask

	task automatic send_burst(input int n, input logic gaps);
		for (int i = 0; i < n; i++) begin
			if (gaps && ($urandom % 4 == 0)) begin
				@(posedge clk_sys);
				#1;
			end
			core_sample = stereo_sample_t'($urandom);
			core_valid  = 1'b1;
			@(negedge clk_sys);
			while (!core_ready) begin
				@(negedge clk_sys);
			end
			@(posedge clk_sys);
			#1;
			core_valid = 1'b0;
		end
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(posedge clk_sys);
		end
		repeat (2) @(posedge clk_sys);
		#1;
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		seed_ret    = $urandom(32'h8762_3706);
		resetd      = 1'b1;
		host_uio    = 1'b0;
		host_clk    = 1'b0;
		host_din    = '0;
		core_sample = '0;
		core_valid  = 1'b0;
		audio_fmt   = '0;
		core_led    = 5'b10_01_1;
		out_ready   = 1'b1;
		bp_en       = 1'b0;
		held_valid  = 1'b0;
		model_vol   = '0;
		model_led   = '0;
		in_count    = 0;
		out_count   = 0;
		data_errs   = 0;
		proto_errs  = 0;
		repeat (8) @(posedge clk_sys);
		#1;
		resetd = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1;

		// Reset state
		check_value("out_valid", out_valid, 0);
		check_value("cfg_flags", cfg_flags, 0);
		check_value("board_led", board_led, expected_leds(model_led, core_led));

		// Register loads and an ignored opcode
		host_command(CMD_CFG, 16'h80E8);
		check_value("cfg_flags", cfg_flags, 16'h80E8);
		host_close();
		host_command(CMD_LED, 16'hE0A5);
		model_led = 16'hE0A5;
		check_value("board_led", board_led, expected_leds(model_led, core_led));
		host_close();
		core_led = 5'b00_10_0;
		repeat (2) @(posedge clk_sys);
		#1;
		check_value("board_led", board_led, expected_leds(model_led, core_led));
		host_command(8'h7E, 16'h5A3C);
		check_value("cfg_flags", cfg_flags, 16'h80E8);
		check_value("board_led", board_led, expected_leds(model_led, core_led));
		host_close();

		// Every format with the sink always ready
		for (int sg = 0; sg < 2; sg++) begin
			for (int d = 0; d < 4; d++) begin
				audio_fmt.is_signed = sg[0];
				audio_fmt.depth     = mix_depth_t'(d);
				send_burst(FMT_SAMPLES, 1'b0);
				wait_drain();
			end
		end

		// Random back-pressure fills the FIFO
		audio_fmt = {1'b1, MIX_QUARTER};
		bp_en = 1'b1;
		send_burst(BP_SAMPLES, 1'b1);
		wait_drain();
		bp_en = 1'b0;

		// Mute, then shifts for both signedness settings
		set_volume(5'b1_0101);
		send_burst(VOL_SAMPLES, 1'b0);
		wait_drain();
		for (int sg = 0; sg < 2; sg++) begin
			audio_fmt = {sg[0], MIX_HALF};
			set_volume(5'd0);
			send_burst(VOL_SAMPLES, 1'b0);
			wait_drain();
			set_volume(5'd3);
			send_burst(VOL_SAMPLES, 1'b1);
			wait_drain();
			set_volume(5'd15);
			send_burst(VOL_SAMPLES, 1'b0);
			wait_drain();
		end

		assert (in_count == out_count) else begin
			$display("Accepted %0d samples but saw %0d outputs", in_count, out_count);
			proto_errs++;
		end
		$display("Errors: data %0d, protocol %0d", data_errs, proto_errs);
		if (data_errs + proto_errs == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: sys_top.f
+incdir+.
host_pkg.sv
audio_pkg.sv
host_cmd_decoder.sv
audio_mixer.sv
sample_fifo.sv
volume_stage.sv
led_driver.sv
sys_top.sv
tb_sys_top.sv

// File: Bender.yml
package:
  name: sys_top

export_include_dirs:
  - .

sources:
  - files:
      - host_pkg.sv
      - audio_pkg.sv
      - host_cmd_decoder.sv
      - audio_mixer.sv
      - sample_fifo.sv
      - volume_stage.sv
      - led_driver.sv
      - sys_top.sv
  - target: test
    files:
      - tb_sys_top.sv
